// File: ctrl_pkg.sv
package ctrl_pkg;

    // Controller states
    typedef enum logic [6:0] {
        fetch            = 7'd0,
        ir_pc            = 7'd1,
        decode           = 7'd2,
        overflow_rd      = 7'd3,
        and_op           = 7'd4,
        rd_write_alu_out = 7'd5,
        add_op           = 7'd6,
        sub_op           = 7'd7,
        epc_write        = 7'd8,
        pc_exception     = 7'd9,
        addiu_op         = 7'd10,
        rt_write_alu_out = 7'd11,
        addi_op          = 7'd12,
        overflow_rt      = 7'd13,
        break_op         = 7'd14,
        rte_op           = 7'd15,
        jr_op            = 7'd16,
        slt_op           = 7'd17,
        slti_op          = 7'd18,
        lui_op           = 7'd19,
        branch_compare   = 7'd20,
        beq_op           = 7'd21,
        bne_op           = 7'd22,
        ble_op           = 7'd23,
        bgt_op           = 7'd24,
        branch_pc        = 7'd25
    } ctrl_state_e;

    typedef enum logic [5:0] {
        op_r_type = 6'h00,
        op_beq    = 6'h04,
        op_bne    = 6'h05,
        op_ble    = 6'h06,
        op_bgt    = 6'h07,
        op_addi   = 6'h08,
        op_addiu  = 6'h09,
        op_slti   = 6'h0a,
        op_lui    = 6'h0f
    } opcode_e;

    // R-type function field
    typedef enum logic [5:0] {
        fn_jr    = 6'h08,
        fn_break = 6'h0d,
        fn_rte   = 6'h13,
        fn_add   = 6'h20,
        fn_sub   = 6'h22,
        fn_and   = 6'h24,
        fn_slt   = 6'h2a
    } funct_e;

    typedef enum logic [3:0] {
        cls_and, cls_add, cls_sub, cls_slt,
        cls_jr, cls_break, cls_rte,
        cls_addi, cls_addiu, cls_slti, cls_lui,
        cls_beq, cls_bne, cls_ble, cls_bgt,
        cls_invalid
    } instr_class_e;

    typedef enum logic [2:0] {
        alu_load_a = 3'b000,
        alu_add    = 3'b001,
        alu_sub    = 3'b010,
        alu_and    = 3'b011,
        alu_load_b = 3'b111
    } alu_op_e;

    typedef enum logic [1:0] {
        exc_invalid  = 2'd0,
        exc_overflow = 2'd1
    } exc_cause_e;

    localparam int i_or_d_w     = 2;
    localparam int reg_dst_w    = 2;
    localparam int mem_to_reg_w = 3;
    localparam int alu_src_b_w  = 2;
    localparam int pc_source_w  = 3;

    // ALU B operand: 4, immediate, shifted branch offset
    localparam logic [alu_src_b_w-1:0] alu_src_b_four   = 2'd1;
    localparam logic [alu_src_b_w-1:0] alu_src_b_imm    = 2'd2;
    localparam logic [alu_src_b_w-1:0] alu_src_b_branch = 2'd3;

    localparam logic [pc_source_w-1:0] pc_src_alu     = 3'd0;
    localparam logic [pc_source_w-1:0] pc_src_alu_out = 3'd1;
    localparam logic [pc_source_w-1:0] pc_src_epc     = 3'd3;
    localparam logic [pc_source_w-1:0] pc_src_handler = 3'd4;

    localparam logic [mem_to_reg_w-1:0] mem_to_reg_lui = 3'd4;
    localparam logic [mem_to_reg_w-1:0] mem_to_reg_lt  = 3'd5;

    localparam logic [i_or_d_w-1:0] i_or_d_handler = 2'd2;

    typedef struct packed {
        logic [2:0]              alu_ctrl;
        logic                    mem_read;
        logic                    ir_write;
        logic                    reg_write;
        logic                    pc_write;
        logic                    epc_write;
        logic                    write_a;
        logic                    write_b;
        logic                    alu_out_write;
        logic [i_or_d_w-1:0]     i_or_d;
        logic [reg_dst_w-1:0]    reg_dst;
        logic [mem_to_reg_w-1:0] mem_to_reg;
        logic                    alu_src_a;
        logic [alu_src_b_w-1:0]  alu_src_b;
        logic [pc_source_w-1:0]  pc_source;
    } ctrl_word_t;

endpackage

// File: instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder (
    input  logic [5:0]            opcode,
    input  logic [5:0]            funct,
    output ctrl_pkg::instr_class_e instr_class
);

    always_comb begin
        instr_class = ctrl_pkg::cls_invalid;
        case (opcode)
            ctrl_pkg::op_r_type: begin
                // Funct only matters for R-type
                case (funct)
                    ctrl_pkg::fn_and:   instr_class = ctrl_pkg::cls_and;
                    ctrl_pkg::fn_add:   instr_class = ctrl_pkg::cls_add;
                    ctrl_pkg::fn_sub:   instr_class = ctrl_pkg::cls_sub;
                    ctrl_pkg::fn_slt:   instr_class = ctrl_pkg::cls_slt;
                    ctrl_pkg::fn_jr:    instr_class = ctrl_pkg::cls_jr;
                    ctrl_pkg::fn_break: instr_class = ctrl_pkg::cls_break;
                    ctrl_pkg::fn_rte:   instr_class = ctrl_pkg::cls_rte;
                    default:            instr_class = ctrl_pkg::cls_invalid;
                endcase
            end
            ctrl_pkg::op_addi:  instr_class = ctrl_pkg::cls_addi;
            ctrl_pkg::op_addiu: instr_class = ctrl_pkg::cls_addiu;
            ctrl_pkg::op_slti:  instr_class = ctrl_pkg::cls_slti;
            ctrl_pkg::op_lui:   instr_class = ctrl_pkg::cls_lui;
            ctrl_pkg::op_beq:   instr_class = ctrl_pkg::cls_beq;
            ctrl_pkg::op_bne:   instr_class = ctrl_pkg::cls_bne;
            ctrl_pkg::op_ble:   instr_class = ctrl_pkg::cls_ble;
            ctrl_pkg::op_bgt:   instr_class = ctrl_pkg::cls_bgt;
            default:            instr_class = ctrl_pkg::cls_invalid;
        endcase
    end

endmodule

// File: ctrl_sequencer.sv
`timescale 1ns/1ps

module ctrl_sequencer (
    input  logic                   clock,
    input  logic                   reset,
    input  ctrl_pkg::instr_class_e instr_class,
    input  logic                   equal_to,
    input  logic                   greater_than,
    input  logic                   overflow,
    output ctrl_pkg::ctrl_state_e  state,
    output ctrl_pkg::exc_cause_e   exc_cause
);

    ctrl_pkg::ctrl_state_e next_state;

    always_comb begin
        next_state = ctrl_pkg::fetch;
        case (state)
            ctrl_pkg::fetch:  next_state = ctrl_pkg::ir_pc;
            ctrl_pkg::ir_pc:  next_state = ctrl_pkg::decode;
            ctrl_pkg::decode: begin
                case (instr_class)
                    ctrl_pkg::cls_and:   next_state = ctrl_pkg::and_op;
                    ctrl_pkg::cls_add:   next_state = ctrl_pkg::add_op;
                    ctrl_pkg::cls_sub:   next_state = ctrl_pkg::sub_op;
                    ctrl_pkg::cls_slt:   next_state = ctrl_pkg::slt_op;
                    ctrl_pkg::cls_jr:    next_state = ctrl_pkg::jr_op;
                    ctrl_pkg::cls_break: next_state = ctrl_pkg::break_op;
                    ctrl_pkg::cls_rte:   next_state = ctrl_pkg::rte_op;
                    ctrl_pkg::cls_addi:  next_state = ctrl_pkg::addi_op;
                    ctrl_pkg::cls_addiu: next_state = ctrl_pkg::addiu_op;
                    ctrl_pkg::cls_slti:  next_state = ctrl_pkg::slti_op;
                    ctrl_pkg::cls_lui:   next_state = ctrl_pkg::lui_op;
                    ctrl_pkg::cls_beq,
                    ctrl_pkg::cls_bne,
                    ctrl_pkg::cls_ble,
                    ctrl_pkg::cls_bgt:   next_state = ctrl_pkg::branch_compare;
                    default:             next_state = ctrl_pkg::epc_write;
                endcase
            end
            ctrl_pkg::and_op:   next_state = ctrl_pkg::rd_write_alu_out;
            ctrl_pkg::add_op,
            ctrl_pkg::sub_op:   next_state = ctrl_pkg::overflow_rd;
            ctrl_pkg::addi_op:  next_state = ctrl_pkg::overflow_rt;
            ctrl_pkg::addiu_op: next_state = ctrl_pkg::rt_write_alu_out;
            // Overflow flag is valid one cycle after the ALU op
            ctrl_pkg::overflow_rd: begin
                next_state = overflow ? ctrl_pkg::epc_write : ctrl_pkg::rd_write_alu_out;
            end
            ctrl_pkg::overflow_rt: begin
                next_state = overflow ? ctrl_pkg::epc_write : ctrl_pkg::rt_write_alu_out;
            end
            ctrl_pkg::branch_compare: begin
                // Opcode still held, so the class still names the branch
                case (instr_class)
                    ctrl_pkg::cls_beq: next_state = ctrl_pkg::beq_op;
                    ctrl_pkg::cls_bne: next_state = ctrl_pkg::bne_op;
                    ctrl_pkg::cls_ble: next_state = ctrl_pkg::ble_op;
                    ctrl_pkg::cls_bgt: next_state = ctrl_pkg::bgt_op;
                    default:           next_state = ctrl_pkg::fetch;
                endcase
            end
            ctrl_pkg::beq_op: next_state = equal_to ? ctrl_pkg::branch_pc : ctrl_pkg::fetch;
            ctrl_pkg::bne_op: next_state = equal_to ? ctrl_pkg::fetch : ctrl_pkg::branch_pc;
            ctrl_pkg::ble_op: next_state = greater_than ? ctrl_pkg::fetch : ctrl_pkg::branch_pc;
            ctrl_pkg::bgt_op: next_state = greater_than ? ctrl_pkg::branch_pc : ctrl_pkg::fetch;
            ctrl_pkg::epc_write: next_state = ctrl_pkg::pc_exception;
            default: next_state = ctrl_pkg::fetch;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= ctrl_pkg::fetch;
        end else begin
            state <= next_state;
        end
    end

    // Cause is latched on the way into epc_write
    always_ff @(posedge clock) begin
        if (reset) begin
            exc_cause <= ctrl_pkg::exc_invalid;
        end else if (next_state == ctrl_pkg::epc_write) begin
            if (state == ctrl_pkg::decode) begin
                exc_cause <= ctrl_pkg::exc_invalid;
            end else begin
                exc_cause <= ctrl_pkg::exc_overflow;
            end
        end
    end

endmodule

// File: ctrl_word_table.sv
`timescale 1ns/1ps

module ctrl_word_table (
    input  ctrl_pkg::ctrl_state_e state,
    output ctrl_pkg::ctrl_word_t  ctrl_word
);

    always_comb begin
        ctrl_word = '0;
        case (state)
            ctrl_pkg::fetch: begin
                ctrl_word.mem_read = 1'b1;
            end
            // PC + 4 and instruction register load
            ctrl_pkg::ir_pc: begin
                ctrl_word.pc_write  = 1'b1;
                ctrl_word.ir_write  = 1'b1;
                ctrl_word.alu_ctrl  = ctrl_pkg::alu_add;
                ctrl_word.alu_src_b = ctrl_pkg::alu_src_b_four;
                ctrl_word.pc_source = ctrl_pkg::pc_src_alu;
            end
            // Register read plus speculative branch target
            ctrl_pkg::decode: begin
                ctrl_word.write_a       = 1'b1;
                ctrl_word.write_b       = 1'b1;
                ctrl_word.alu_out_write = 1'b1;
                ctrl_word.alu_ctrl      = ctrl_pkg::alu_add;
                ctrl_word.alu_src_b     = ctrl_pkg::alu_src_b_branch;
            end
            ctrl_pkg::and_op,
            ctrl_pkg::add_op,
            ctrl_pkg::sub_op: begin
                ctrl_word.alu_out_write = 1'b1;
                ctrl_word.alu_src_a     = 1'b1;
                if (state == ctrl_pkg::and_op) begin
                    ctrl_word.alu_ctrl = ctrl_pkg::alu_and;
                end else if (state == ctrl_pkg::add_op) begin
                    ctrl_word.alu_ctrl = ctrl_pkg::alu_add;
                end else begin
                    ctrl_word.alu_ctrl = ctrl_pkg::alu_sub;
                end
            end
            ctrl_pkg::addi_op,
            ctrl_pkg::addiu_op: begin
                ctrl_word.alu_out_write = 1'b1;
                ctrl_word.alu_src_a     = 1'b1;
                ctrl_word.alu_src_b     = ctrl_pkg::alu_src_b_imm;
                ctrl_word.alu_ctrl      = ctrl_pkg::alu_add;
            end
            ctrl_pkg::rd_write_alu_out: begin
                ctrl_word.reg_write = 1'b1;
                ctrl_word.reg_dst   = 2'd1;
            end
            ctrl_pkg::rt_write_alu_out: begin
                ctrl_word.reg_write = 1'b1;
            end
            ctrl_pkg::slt_op: begin
                ctrl_word.reg_write  = 1'b1;
                ctrl_word.mem_to_reg = ctrl_pkg::mem_to_reg_lt;
                ctrl_word.alu_src_a  = 1'b1;
                ctrl_word.reg_dst    = 2'd1;
            end
            ctrl_pkg::slti_op: begin
                ctrl_word.reg_write  = 1'b1;
                ctrl_word.mem_to_reg = ctrl_pkg::mem_to_reg_lt;
                ctrl_word.alu_src_a  = 1'b1;
                ctrl_word.alu_src_b  = ctrl_pkg::alu_src_b_imm;
            end
            ctrl_pkg::lui_op: begin
                ctrl_word.reg_write  = 1'b1;
                ctrl_word.mem_to_reg = ctrl_pkg::mem_to_reg_lui;
            end
            // Back the PC up by 4 onto the break itself
            ctrl_pkg::break_op: begin
                ctrl_word.pc_write  = 1'b1;
                ctrl_word.alu_ctrl  = ctrl_pkg::alu_sub;
                ctrl_word.alu_src_b = ctrl_pkg::alu_src_b_four;
                ctrl_word.pc_source = ctrl_pkg::pc_src_alu;
            end
            ctrl_pkg::rte_op: begin
                ctrl_word.pc_write  = 1'b1;
                ctrl_word.pc_source = ctrl_pkg::pc_src_epc;
            end
            ctrl_pkg::jr_op: begin
                ctrl_word.pc_write  = 1'b1;
                ctrl_word.alu_src_a = 1'b1;
                ctrl_word.alu_ctrl  = ctrl_pkg::alu_load_a;
            end
            // EPC gets PC - 4 while the handler vector is read
            ctrl_pkg::epc_write: begin
                ctrl_word.mem_read  = 1'b1;
                ctrl_word.epc_write = 1'b1;
                ctrl_word.i_or_d    = ctrl_pkg::i_or_d_handler;
                ctrl_word.alu_ctrl  = ctrl_pkg::alu_sub;
                ctrl_word.alu_src_b = ctrl_pkg::alu_src_b_four;
            end
            ctrl_pkg::pc_exception: begin
                ctrl_word.pc_write  = 1'b1;
                ctrl_word.pc_source = ctrl_pkg::pc_src_handler;
            end
            ctrl_pkg::branch_compare: begin
                ctrl_word.alu_src_a = 1'b1;
            end
            ctrl_pkg::branch_pc: begin
                ctrl_word.pc_write  = 1'b1;
                ctrl_word.pc_source = ctrl_pkg::pc_src_alu_out;
            end
            default: begin
                ctrl_word = '0;
            end
        endcase
    end

endmodule

// File: ctrl_unit.sv
`timescale 1ns/1ps

module ctrl_unit (
    input  logic                              clock,
    input  logic                              reset,
    input  logic [5:0]                        opcode,
    input  logic [5:0]                        funct,
    input  logic                              greater_than,
    input  logic                              equal_to,
    input  logic                              overflow,
    output logic [2:0]                        alu_ctrl,
    output logic                              mem_read,
    output logic                              ir_write,
    output logic                              reg_write,
    output logic                              pc_write,
    output logic                              epc_write,
    output logic                              write_a,
    output logic                              write_b,
    output logic                              alu_out_write,
    output logic [ctrl_pkg::i_or_d_w-1:0]     i_or_d,
    output logic [ctrl_pkg::reg_dst_w-1:0]    reg_dst,
    output logic [ctrl_pkg::mem_to_reg_w-1:0] mem_to_reg,
    output logic                              alu_src_a,
    output logic [ctrl_pkg::alu_src_b_w-1:0]  alu_src_b,
    output logic [ctrl_pkg::pc_source_w-1:0]  pc_source,
    output logic [1:0]                        exception
);

    ctrl_pkg::instr_class_e instr_class;
    ctrl_pkg::ctrl_state_e  state;
    ctrl_pkg::exc_cause_e   exc_cause;
    ctrl_pkg::ctrl_word_t   ctrl_word;

    instr_decoder u_decoder (
        .opcode      (opcode),
        .funct       (funct),
        .instr_class (instr_class)
    );

    ctrl_sequencer u_sequencer (
        .clock        (clock),
        .reset        (reset),
        .instr_class  (instr_class),
        .equal_to     (equal_to),
        .greater_than (greater_than),
        .overflow     (overflow),
        .state        (state),
        .exc_cause    (exc_cause)
    );

    ctrl_word_table u_table (
        .state     (state),
        .ctrl_word (ctrl_word)
    );

    // Spread the control word onto the datapath strobes
    assign alu_ctrl      = ctrl_word.alu_ctrl;
    assign mem_read      = ctrl_word.mem_read;
    assign ir_write      = ctrl_word.ir_write;
    assign reg_write     = ctrl_word.reg_write;
    assign pc_write      = ctrl_word.pc_write;
    assign epc_write     = ctrl_word.epc_write;
    assign write_a       = ctrl_word.write_a;
    assign write_b       = ctrl_word.write_b;
    assign alu_out_write = ctrl_word.alu_out_write;
    assign i_or_d        = ctrl_word.i_or_d;
    assign reg_dst       = ctrl_word.reg_dst;
    assign mem_to_reg    = ctrl_word.mem_to_reg;
    assign alu_src_a     = ctrl_word.alu_src_a;
    assign alu_src_b     = ctrl_word.alu_src_b;
    assign pc_source     = ctrl_word.pc_source;
    assign exception     = exc_cause;

endmodule

// File: tb_ctrl_unit.sv
`timescale 1ns/1ps

module tb_ctrl_unit;

    localparam int clk_period   = 40;
    localparam int reset_cycles = 5;
    localparam int max_instrs   = 50;
    localparam int max_cpi      = 8;
    // Two resets plus the longest possible instruction stream
    localparam int timeout_ns   = (2 * reset_cycles + max_instrs * max_cpi) * clk_period;

    logic                              clock;
    logic                              reset;
    logic [5:0]                        opcode;
    logic [5:0]                        funct;
    logic                              greater_than;
    logic                              equal_to;
    logic                              overflow;
    logic [2:0]                        alu_ctrl;
    logic                              mem_read;
    logic                              ir_write;
    logic                              reg_write;
    logic                              pc_write;
    logic                              epc_write;
    logic                              write_a;
    logic                              write_b;
    logic                              alu_out_write;
    logic [ctrl_pkg::i_or_d_w-1:0]     i_or_d;
    logic [ctrl_pkg::reg_dst_w-1:0]    reg_dst;
    logic [ctrl_pkg::mem_to_reg_w-1:0] mem_to_reg;
    logic                              alu_src_a;
    logic [ctrl_pkg::alu_src_b_w-1:0]  alu_src_b;
    logic [ctrl_pkg::pc_source_w-1:0]  pc_source;
    logic [1:0]                        exception;

    ctrl_pkg::ctrl_word_t dut_word;
    logic [31:0]          lcg_state;
    int                   error_count;

    ctrl_unit u_dut (.*);

    // Field order follows the packed struct
    assign dut_word = {alu_ctrl, mem_read, ir_write, reg_write, pc_write, epc_write,
                       write_a, write_b, alu_out_write, i_or_d, reg_dst, mem_to_reg,
                       alu_src_a, alu_src_b, pc_source};

    initial begin
        clock = 1'b0;
        forever #(clk_period / 2) clock = ~clock;
    end

    initial begin
        #(timeout_ns);
        $display("Timeout: the control unit hung and never finished the test sequence");
        $display("Done: errors found");
        $fatal(1, "watchdog expired");
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return {17'd0, lcg_state[30:16]};
    endfunction

    // State reached from decode
    function automatic ctrl_pkg::ctrl_state_e decode_target(logic [5:0] op, logic [5:0] fn);
        ctrl_pkg::ctrl_state_e s;
        s = ctrl_pkg::epc_write;
        case (op)
            ctrl_pkg::op_r_type: begin
                case (fn)
                    ctrl_pkg::fn_and:   s = ctrl_pkg::and_op;
                    ctrl_pkg::fn_add:   s = ctrl_pkg::add_op;
                    ctrl_pkg::fn_sub:   s = ctrl_pkg::sub_op;
                    ctrl_pkg::fn_slt:   s = ctrl_pkg::slt_op;
                    ctrl_pkg::fn_jr:    s = ctrl_pkg::jr_op;
                    ctrl_pkg::fn_break: s = ctrl_pkg::break_op;
                    ctrl_pkg::fn_rte:   s = ctrl_pkg::rte_op;
                    default:            s = ctrl_pkg::epc_write;
                endcase
            end
            ctrl_pkg::op_addi:  s = ctrl_pkg::addi_op;
            ctrl_pkg::op_addiu: s = ctrl_pkg::addiu_op;
            ctrl_pkg::op_slti:  s = ctrl_pkg::slti_op;
            ctrl_pkg::op_lui:   s = ctrl_pkg::lui_op;
            ctrl_pkg::op_beq,
            ctrl_pkg::op_bne,
            ctrl_pkg::op_ble,
            ctrl_pkg::op_bgt:   s = ctrl_pkg::branch_compare;
            default:            s = ctrl_pkg::epc_write;
        endcase
        return s;
    endfunction

    function automatic ctrl_pkg::ctrl_state_e model_next(ctrl_pkg::ctrl_state_e s,
                                                         logic [5:0] op, logic [5:0] fn,
                                                         logic eq, logic gt, logic ov);
        case (s)
            ctrl_pkg::fetch:            return ctrl_pkg::ir_pc;
            ctrl_pkg::ir_pc:            return ctrl_pkg::decode;
            ctrl_pkg::decode:           return decode_target(op, fn);
            ctrl_pkg::and_op:           return ctrl_pkg::rd_write_alu_out;
            ctrl_pkg::add_op:           return ctrl_pkg::overflow_rd;
            ctrl_pkg::sub_op:           return ctrl_pkg::overflow_rd;
            ctrl_pkg::addi_op:          return ctrl_pkg::overflow_rt;
            ctrl_pkg::addiu_op:         return ctrl_pkg::rt_write_alu_out;
            ctrl_pkg::overflow_rd:      return ov ? ctrl_pkg::epc_write : ctrl_pkg::rd_write_alu_out;
            ctrl_pkg::overflow_rt:      return ov ? ctrl_pkg::epc_write : ctrl_pkg::rt_write_alu_out;
            ctrl_pkg::branch_compare: begin
                if (op == ctrl_pkg::op_beq) return ctrl_pkg::beq_op;
                if (op == ctrl_pkg::op_bne) return ctrl_pkg::bne_op;
                if (op == ctrl_pkg::op_ble) return ctrl_pkg::ble_op;
                return ctrl_pkg::bgt_op;
            end
            ctrl_pkg::beq_op:           return eq ? ctrl_pkg::branch_pc : ctrl_pkg::fetch;
            ctrl_pkg::bne_op:           return !eq ? ctrl_pkg::branch_pc : ctrl_pkg::fetch;
            ctrl_pkg::ble_op:           return !gt ? ctrl_pkg::branch_pc : ctrl_pkg::fetch;
            ctrl_pkg::bgt_op:           return gt ? ctrl_pkg::branch_pc : ctrl_pkg::fetch;
            ctrl_pkg::epc_write:        return ctrl_pkg::pc_exception;
            default:                    return ctrl_pkg::fetch;
        endcase
    endfunction

    function automatic ctrl_pkg::ctrl_word_t model_word(ctrl_pkg::ctrl_state_e s);
        ctrl_pkg::ctrl_word_t w;
        w = '0;
        case (s)
            ctrl_pkg::fetch: w.mem_read = 1'b1;
            ctrl_pkg::ir_pc: begin
                w.pc_write  = 1'b1;
                w.ir_write  = 1'b1;
                w.alu_ctrl  = ctrl_pkg::alu_add;
                w.alu_src_b = ctrl_pkg::alu_src_b_four;
            end
            ctrl_pkg::decode: begin
                w.write_a       = 1'b1;
                w.write_b       = 1'b1;
                w.alu_out_write = 1'b1;
                w.alu_ctrl      = ctrl_pkg::alu_add;
                w.alu_src_b     = ctrl_pkg::alu_src_b_branch;
            end
            ctrl_pkg::and_op, ctrl_pkg::add_op, ctrl_pkg::sub_op,
            ctrl_pkg::addi_op, ctrl_pkg::addiu_op: begin
                w.alu_out_write = 1'b1;
                w.alu_src_a     = 1'b1;
                w.alu_ctrl      = ctrl_pkg::alu_add;
                if (s == ctrl_pkg::and_op) w.alu_ctrl = ctrl_pkg::alu_and;
                if (s == ctrl_pkg::sub_op) w.alu_ctrl = ctrl_pkg::alu_sub;
                if (s == ctrl_pkg::addi_op || s == ctrl_pkg::addiu_op) begin
                    w.alu_src_b = ctrl_pkg::alu_src_b_imm;
                end
            end
            ctrl_pkg::rd_write_alu_out: begin
                w.reg_write = 1'b1;
                w.reg_dst   = 2'd1;
            end
            ctrl_pkg::rt_write_alu_out: w.reg_write = 1'b1;
            ctrl_pkg::slt_op, ctrl_pkg::slti_op: begin
                w.reg_write  = 1'b1;
                w.mem_to_reg = ctrl_pkg::mem_to_reg_lt;
                w.alu_src_a  = 1'b1;
                if (s == ctrl_pkg::slt_op) w.reg_dst = 2'd1;
                else w.alu_src_b = ctrl_pkg::alu_src_b_imm;
            end
            ctrl_pkg::lui_op: begin
                w.reg_write  = 1'b1;
                w.mem_to_reg = ctrl_pkg::mem_to_reg_lui;
            end
            ctrl_pkg::break_op: begin
                w.pc_write  = 1'b1;
                w.alu_ctrl  = ctrl_pkg::alu_sub;
                w.alu_src_b = ctrl_pkg::alu_src_b_four;
            end
            ctrl_pkg::rte_op: begin
                w.pc_write  = 1'b1;
                w.pc_source = ctrl_pkg::pc_src_epc;
            end
            ctrl_pkg::jr_op: begin
                w.pc_write  = 1'b1;
                w.alu_src_a = 1'b1;
                w.alu_ctrl  = ctrl_pkg::alu_load_a;
            end
            ctrl_pkg::epc_write: begin
                w.mem_read  = 1'b1;
                w.epc_write = 1'b1;
                w.i_or_d    = ctrl_pkg::i_or_d_handler;
                w.alu_ctrl  = ctrl_pkg::alu_sub;
                w.alu_src_b = ctrl_pkg::alu_src_b_four;
            end
            ctrl_pkg::pc_exception: begin
                w.pc_write  = 1'b1;
                w.pc_source = ctrl_pkg::pc_src_handler;
            end
            ctrl_pkg::branch_compare: w.alu_src_a = 1'b1;
            ctrl_pkg::branch_pc: begin
                w.pc_write  = 1'b1;
                w.pc_source = ctrl_pkg::pc_src_alu_out;
            end
            default: w = '0;
        endcase
        return w;
    endfunction

    task automatic check_word(input string name, input ctrl_pkg::ctrl_word_t exp,
                              input ctrl_pkg::ctrl_word_t act);
        if (act !== exp) begin
            error_count++;
            $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
            $display("Done: errors found");
            $fatal(1, "control word mismatch");
        end
    endtask

    task automatic check_cause(input string name, input ctrl_pkg::exc_cause_e exp,
                               input ctrl_pkg::exc_cause_e act);
        if (act !== exp) begin
            error_count++;
            $display("[FAIL] %s: expected %s, actual %s", name, exp.name(), act.name());
            $display("Done: errors found");
            $fatal(1, "exception cause mismatch");
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            error_count++;
            $display("[FAIL] %s cycles: expected %0d, actual %0d", name, exp, act);
            $display("Done: errors found");
            $fatal(1, "cycle count mismatch");
        end
    endtask

    task automatic apply_reset();
        @(posedge clock);
        #2;
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clock);
        #2;
        reset = 1'b0;
    endtask

    // Starts 2 ns into a fetch cycle and returns once the DUT is back in fetch
    task automatic run_instr(input string name, input logic [5:0] op, input logic [5:0] fn,
                             input logic eq, input logic gt, input logic ov,
                             input int exp_cycles);
        ctrl_pkg::ctrl_state_e s;
        ctrl_pkg::ctrl_word_t  fetch_word;
        int cycles;
        opcode       = op;
        funct        = fn;
        equal_to     = eq;
        greater_than = gt;
        overflow     = ov;
        s            = ctrl_pkg::fetch;
        fetch_word   = model_word(ctrl_pkg::fetch);
        cycles       = 0;
        do begin
            @(negedge clock);
            check_word($sformatf("%s/%s", name, s.name()), model_word(s), dut_word);
            s = model_next(s, op, fn, eq, gt, ov);
            @(posedge clock);
            #2;
            cycles++;
        end while (dut_word !== fetch_word && cycles < max_cpi);
        check_count(name, exp_cycles, cycles);
    endtask

    // Flags drawn as equal, greater or less
    task automatic run_branch(input string name, input logic [5:0] op);
        logic [31:0] pick;
        logic        eq;
        logic        gt;
        logic        taken;
        repeat (4) begin
            pick  = next_rand() % 32'd3;
            eq    = (pick == 32'd0);
            gt    = (pick == 32'd1);
            taken = 1'b0;
            case (op)
                ctrl_pkg::op_beq: taken = eq;
                ctrl_pkg::op_bne: taken = !eq;
                ctrl_pkg::op_ble: taken = !gt;
                default:          taken = gt;
            endcase
            run_instr(name, op, 6'h00, eq, gt, 1'b0, taken ? 6 : 5);
        end
    endtask

    initial begin
        ctrl_pkg::ctrl_word_t reset_word;
        reset        = 1'b1;
        opcode       = 6'h00;
        funct        = 6'h00;
        greater_than = 1'b0;
        equal_to     = 1'b0;
        overflow     = 1'b0;
        lcg_state    = 32'd1423;
        error_count  = 0;

        apply_reset();
        @(negedge clock);
        reset_word          = '0;
        reset_word.mem_read = 1'b1;
        check_word("reset", reset_word, dut_word);
        check_cause("reset", ctrl_pkg::exc_invalid, ctrl_pkg::exc_cause_e'(exception));
        apply_reset();

        run_instr("and", ctrl_pkg::op_r_type, ctrl_pkg::fn_and, 1'b0, 1'b0, 1'b0, 5);
        run_instr("add", ctrl_pkg::op_r_type, ctrl_pkg::fn_add, 1'b0, 1'b0, 1'b0, 6);
        run_instr("sub", ctrl_pkg::op_r_type, ctrl_pkg::fn_sub, 1'b0, 1'b0, 1'b0, 6);
        run_instr("addiu", ctrl_pkg::op_addiu, 6'h00, 1'b0, 1'b0, 1'b0, 5);
        run_instr("addi", ctrl_pkg::op_addi, 6'h00, 1'b0, 1'b0, 1'b0, 6);
        run_instr("slt", ctrl_pkg::op_r_type, ctrl_pkg::fn_slt, 1'b0, 1'b0, 1'b0, 4);
        run_instr("slti", ctrl_pkg::op_slti, 6'h00, 1'b0, 1'b0, 1'b0, 4);
        run_instr("lui", ctrl_pkg::op_lui, 6'h00, 1'b0, 1'b0, 1'b0, 4);

        run_instr("add_ovf", ctrl_pkg::op_r_type, ctrl_pkg::fn_add, 1'b0, 1'b0, 1'b1, 7);
        check_cause("add_ovf", ctrl_pkg::exc_overflow, ctrl_pkg::exc_cause_e'(exception));
        run_instr("addi_ovf", ctrl_pkg::op_addi, 6'h00, 1'b0, 1'b0, 1'b1, 7);
        check_cause("addi_ovf", ctrl_pkg::exc_overflow, ctrl_pkg::exc_cause_e'(exception));

        // Undefined opcode, then undefined funct
        run_instr("bad_opcode", 6'h3f, 6'h00, 1'b0, 1'b0, 1'b0, 5);
        check_cause("bad_opcode", ctrl_pkg::exc_invalid, ctrl_pkg::exc_cause_e'(exception));
        run_instr("add_ovf2", ctrl_pkg::op_r_type, ctrl_pkg::fn_sub, 1'b0, 1'b0, 1'b1, 7);
        run_instr("bad_funct", ctrl_pkg::op_r_type, 6'h3f, 1'b0, 1'b0, 1'b0, 5);
        check_cause("bad_funct", ctrl_pkg::exc_invalid, ctrl_pkg::exc_cause_e'(exception));

        run_branch("beq", ctrl_pkg::op_beq);
        run_branch("bne", ctrl_pkg::op_bne);
        run_branch("ble", ctrl_pkg::op_ble);
        run_branch("bgt", ctrl_pkg::op_bgt);

        run_instr("jr", ctrl_pkg::op_r_type, ctrl_pkg::fn_jr, 1'b0, 1'b0, 1'b0, 4);
        run_instr("break", ctrl_pkg::op_r_type, ctrl_pkg::fn_break, 1'b0, 1'b0, 1'b0, 4);
        run_instr("rte", ctrl_pkg::op_r_type, ctrl_pkg::fn_rte, 1'b0, 1'b0, 1'b0, 4);

        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: all.f
ctrl_pkg.sv
instr_decoder.sv
ctrl_sequencer.sv
ctrl_word_table.sv
ctrl_unit.sv
tb_ctrl_unit.sv

// File: run.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -f all.f --top-module tb_ctrl_unit -o sim_ctrl_unit; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_ctrl_unit 2>&1)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Done: no errors"; then
    exit 0
fi
exit 1
